// ==== design/ooo_pkg.sv ====
/*
 * Shared definitions for the out-of-order back end.
 * Widths, register and index types, opcodes and reset constants.
 */

package ooo_pkg;

    // Machine sizes
    localparam int XLEN       = 16;
    localparam int ARCH_REGS  = 8;
    localparam int PHYS_REGS  = 16;
    localparam int ROB_DEPTH  = 8;
    localparam int MUL_STAGES = 3;

    // Registers left over after the identity mapping
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    // Value types
    typedef logic [XLEN-1:0]                    data_t;
    typedef logic [$clog2(ARCH_REGS)-1:0]       arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]       phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]       rob_idx_t;
    typedef logic [$clog2(ROB_DEPTH+1)-1:0]     rob_cnt_t;
    typedef logic [$clog2(FREE_DEPTH)-1:0]      free_idx_t;
    typedef logic [$clog2(FREE_DEPTH+1)-1:0]    free_cnt_t;

    // Register file contents after reset
    localparam data_t DATA_RESET = '0;

    typedef enum logic [1:0] {
        OP_LI  = 2'd0,
        OP_ADD = 2'd1,
        OP_SUB = 2'd2,
        OP_MUL = 2'd3
    } opcode_e;

    // Four-phase ack sequencing at the dispatch port
    typedef enum logic {
        DISP_IDLE = 1'b0,
        DISP_ACK  = 1'b1
    } disp_state_e;

endpackage

// ==== design/cdb_if.sv ====
/*
 * Result request from one functional unit to the CDB arbiter.
 * Four-phase req/ack, payload held stable while req is high.
 */

`timescale 1ns/1ps

interface cdb_if;

    logic               req;
    logic               ack;
    ooo_pkg::data_t     value;
    ooo_pkg::phys_reg_t dest;
    ooo_pkg::rob_idx_t  rob_idx;

    // Functional unit side
    modport unit (output req, output value, output dest, output rob_idx, input ack);

    // Arbiter side
    modport arb (input req, input value, input dest, input rob_idx, output ack);

endinterface

// ==== design/dispatch_unit.sv ====
/*
 * Rename and in-order issue for one instruction at a time.
 * Map table, circular free list and the four-phase dispatch ack.
 */

`timescale 1ns/1ps

module dispatch_unit (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 disp_req_i,
    input  ooo_pkg::opcode_e     disp_op_i,
    input  ooo_pkg::arch_reg_t   disp_rd_i,
    input  ooo_pkg::arch_reg_t   disp_rs1_i,
    input  ooo_pkg::arch_reg_t   disp_rs2_i,
    input  ooo_pkg::data_t       disp_imm_i,
    output logic                 disp_ack_o,
    output ooo_pkg::phys_reg_t   rs1_tag_o,
    output ooo_pkg::phys_reg_t   rs2_tag_o,
    input  logic                 rs1_ready_i,
    input  logic                 rs2_ready_i,
    output logic                 alloc_valid_o,
    output ooo_pkg::phys_reg_t   alloc_tag_o,
    input  logic                 rob_full_i,
    input  ooo_pkg::rob_idx_t    rob_tail_i,
    output logic                 rob_alloc_o,
    output ooo_pkg::arch_reg_t   rob_rd_o,
    output ooo_pkg::phys_reg_t   rob_old_tag_o,
    input  logic                 free_valid_i,
    input  ooo_pkg::phys_reg_t   free_tag_i,
    input  logic                 alu_ready_i,
    input  logic                 mul_ready_i,
    output logic                 issue_alu_o,
    output logic                 issue_mul_o,
    output ooo_pkg::opcode_e     issue_op_o,
    output ooo_pkg::data_t       issue_imm_o,
    output ooo_pkg::phys_reg_t   issue_dest_o,
    output ooo_pkg::rob_idx_t    issue_rob_idx_o
);

    ooo_pkg::phys_reg_t   map_table [ooo_pkg::ARCH_REGS];
    ooo_pkg::phys_reg_t   free_list [ooo_pkg::FREE_DEPTH];
    ooo_pkg::free_idx_t   fl_head;
    ooo_pkg::free_idx_t   fl_tail;
    ooo_pkg::free_cnt_t   fl_count;
    ooo_pkg::disp_state_e state;
    logic                 is_mul;
    logic                 srcs_ok;
    logic                 unit_ok;
    logic                 issue;

    ////////////////////////////////////////
    // Issue decision
    ////////////////////////////////////////

    assign rs1_tag_o = map_table[disp_rs1_i];
    assign rs2_tag_o = map_table[disp_rs2_i];

    assign is_mul = (disp_op_i == ooo_pkg::OP_MUL);
    // Load-immediate reads no sources
    assign srcs_ok = (disp_op_i == ooo_pkg::OP_LI) || (rs1_ready_i && rs2_ready_i);
    assign unit_ok = is_mul ? mul_ready_i : alu_ready_i;

    assign issue = disp_req_i && (state == ooo_pkg::DISP_IDLE) && (fl_count != '0)
                   && !rob_full_i && srcs_ok && unit_ok;

    // New destination comes off the free list head
    assign alloc_valid_o   = issue;
    assign alloc_tag_o     = free_list[fl_head];
    assign rob_alloc_o     = issue;
    assign rob_rd_o        = disp_rd_i;
    assign rob_old_tag_o   = map_table[disp_rd_i];
    assign issue_alu_o     = issue && !is_mul;
    assign issue_mul_o     = issue && is_mul;
    assign issue_op_o      = disp_op_i;
    assign issue_imm_o     = disp_imm_i;
    assign issue_dest_o    = free_list[fl_head];
    assign issue_rob_idx_o = rob_tail_i;

    // Ack is high for the whole DISP_ACK state
    assign disp_ack_o = (state == ooo_pkg::DISP_ACK);

    ////////////////////////////////////////
    // Rename state and handshake
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ooo_pkg::DISP_IDLE;
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= ooo_pkg::free_cnt_t'(ooo_pkg::FREE_DEPTH);
            // Identity map, spare registers on the list
            for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
                map_table[i] <= ooo_pkg::phys_reg_t'(i);
            end
            for (int i = 0; i < ooo_pkg::FREE_DEPTH; i++) begin
                free_list[i] <= ooo_pkg::phys_reg_t'(ooo_pkg::ARCH_REGS + i);
            end
        end else begin
            if (issue) begin
                state                <= ooo_pkg::DISP_ACK;
                map_table[disp_rd_i] <= free_list[fl_head];
                fl_head              <= fl_head + 1'b1;
            end else if (state == ooo_pkg::DISP_ACK && !disp_req_i) begin
                state <= ooo_pkg::DISP_IDLE;
            end
            // Retired registers go back on the tail
            if (free_valid_i) begin
                free_list[fl_tail] <= free_tag_i;
                fl_tail            <= fl_tail + 1'b1;
            end
            if (issue && !free_valid_i) begin
                fl_count <= fl_count - 1'b1;
            end else if (free_valid_i && !issue) begin
                fl_count <= fl_count + 1'b1;
            end
        end
    end

endmodule

// ==== design/phys_reg_file.sv ====
/*
 * Physical register file with one ready bit per register.
 * Two read ports with bus bypass, written from the CDB broadcast.
 */

`timescale 1ns/1ps

module phys_reg_file (
    input  logic               clock,
    input  logic               reset,
    input  ooo_pkg::phys_reg_t rs1_tag_i,
    input  ooo_pkg::phys_reg_t rs2_tag_i,
    output ooo_pkg::data_t     rs1_value_o,
    output ooo_pkg::data_t     rs2_value_o,
    output logic               rs1_ready_o,
    output logic               rs2_ready_o,
    input  logic               alloc_valid_i,
    input  ooo_pkg::phys_reg_t alloc_tag_i,
    input  logic               cdb_valid_i,
    input  ooo_pkg::phys_reg_t cdb_dest_i,
    input  ooo_pkg::data_t     cdb_value_i
);

    ooo_pkg::data_t                  regs [ooo_pkg::PHYS_REGS];
    logic [ooo_pkg::PHYS_REGS-1:0]   ready;
    logic                            rs1_hit;
    logic                            rs2_hit;

    // Same-cycle bus write wins over the stored copy
    assign rs1_hit = cdb_valid_i && (cdb_dest_i == rs1_tag_i);
    assign rs2_hit = cdb_valid_i && (cdb_dest_i == rs2_tag_i);

    assign rs1_value_o = rs1_hit ? cdb_value_i : regs[rs1_tag_i];
    assign rs2_value_o = rs2_hit ? cdb_value_i : regs[rs2_tag_i];
    assign rs1_ready_o = rs1_hit || ready[rs1_tag_i];
    assign rs2_ready_o = rs2_hit || ready[rs2_tag_i];

    always_ff @(posedge clock) begin
        if (reset) begin
            ready <= '1;
            for (int i = 0; i < ooo_pkg::PHYS_REGS; i++) begin
                regs[i] <= ooo_pkg::DATA_RESET;
            end
        end else begin
            // New destination waits for its producer
            if (alloc_valid_i) begin
                ready[alloc_tag_i] <= 1'b0;
            end
            if (cdb_valid_i) begin
                regs[cdb_dest_i]  <= cdb_value_i;
                ready[cdb_dest_i] <= 1'b1;
            end
        end
    end

endmodule

// ==== design/alu_unit.sv ====
/*
 * Single-cycle ALU for load-immediate, add and subtract.
 * Result waits in a holding register until the arbiter takes it.
 */

`timescale 1ns/1ps

module alu_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_i,
    input  ooo_pkg::opcode_e   op_i,
    input  ooo_pkg::data_t     src1_i,
    input  ooo_pkg::data_t     src2_i,
    input  ooo_pkg::data_t     imm_i,
    input  ooo_pkg::phys_reg_t dest_i,
    input  ooo_pkg::rob_idx_t  rob_idx_i,
    output logic               ready_o,
    cdb_if.unit                cdb
);

    ooo_pkg::data_t result;
    logic           full;

    // Wrapping 16-bit arithmetic
    always_comb begin
        case (op_i)
            ooo_pkg::OP_ADD: result = src1_i + src2_i;
            ooo_pkg::OP_SUB: result = src1_i - src2_i;
            default:         result = imm_i;
        endcase
    end

    assign ready_o = !full;

    always_ff @(posedge clock) begin
        if (reset) begin
            full    <= 1'b0;
            cdb.req <= 1'b0;
        end else if (cdb.req && cdb.ack) begin
            // Accepted, drop req and free the register
            cdb.req <= 1'b0;
            full    <= 1'b0;
        end else if (issue_i) begin
            full <= 1'b1;
        end else if (full && !cdb.req && !cdb.ack) begin
            cdb.req <= 1'b1;
        end
    end

    // Holding register
    always_ff @(posedge clock) begin
        if (issue_i) begin
            cdb.value   <= result;
            cdb.dest    <= dest_i;
            cdb.rob_idx <= rob_idx_i;
        end
    end

endmodule

// ==== design/mul_unit.sv ====
/*
 * Three-stage pipelined 16-bit multiplier, low half of the product.
 * Operands, partial products, sum. Freezes behind an unaccepted result.
 */

`timescale 1ns/1ps

module mul_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_i,
    input  ooo_pkg::opcode_e   op_i,
    input  ooo_pkg::data_t     src1_i,
    input  ooo_pkg::data_t     src2_i,
    input  ooo_pkg::phys_reg_t dest_i,
    input  ooo_pkg::rob_idx_t  rob_idx_i,
    output logic               ready_o,
    cdb_if.unit                cdb
);

    logic [ooo_pkg::MUL_STAGES-1:0] vld;
    logic [ooo_pkg::MUL_STAGES-1:0] adv;
    ooo_pkg::phys_reg_t             dest_q [ooo_pkg::MUL_STAGES];
    ooo_pkg::rob_idx_t              rob_q  [ooo_pkg::MUL_STAGES];
    ooo_pkg::data_t                 a_q;
    ooo_pkg::data_t                 b_q;
    ooo_pkg::data_t                 pp_lo;
    ooo_pkg::data_t                 pp_hi;
    ooo_pkg::data_t                 prod_q;
    logic                           start;

    assign start = issue_i && (op_i == ooo_pkg::OP_MUL);

    // Stage moves on when empty or when the stage after it moves
    always_comb begin
        adv[ooo_pkg::MUL_STAGES-1] = !vld[ooo_pkg::MUL_STAGES-1] || (cdb.req && cdb.ack);
        for (int i = ooo_pkg::MUL_STAGES - 2; i >= 0; i--) begin
            adv[i] = !vld[i] || adv[i+1];
        end
    end

    assign ready_o     = adv[0];
    assign cdb.value   = prod_q;
    assign cdb.dest    = dest_q[ooo_pkg::MUL_STAGES-1];
    assign cdb.rob_idx = rob_q[ooo_pkg::MUL_STAGES-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            vld     <= '0;
            cdb.req <= 1'b0;
        end else begin
            if (adv[0]) begin
                vld[0] <= start;
            end
            for (int i = 1; i < ooo_pkg::MUL_STAGES; i++) begin
                if (adv[i]) begin
                    vld[i] <= vld[i-1];
                end
            end
            // Last stage owns the bus request
            if (cdb.req && cdb.ack) begin
                cdb.req <= 1'b0;
            end else if (vld[ooo_pkg::MUL_STAGES-1] && !cdb.req && !cdb.ack) begin
                cdb.req <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (adv[0] && start) begin
            a_q       <= src1_i;
            b_q       <= src2_i;
            dest_q[0] <= dest_i;
            rob_q[0]  <= rob_idx_i;
        end
        if (adv[1]) begin
            // Low byte of b full width, high byte only reaches bits 15:8
            pp_lo <= a_q * b_q[7:0];
            pp_hi <= {8'(a_q[7:0] * b_q[15:8]), 8'h00};
        end
        if (adv[2]) begin
            prod_q <= pp_lo + pp_hi;
        end
        for (int i = 1; i < ooo_pkg::MUL_STAGES; i++) begin
            if (adv[i]) begin
                dest_q[i] <= dest_q[i-1];
                rob_q[i]  <= rob_q[i-1];
            end
        end
    end

endmodule

// ==== design/cdb_arbiter.sv ====
/*
 * Fixed-priority CDB arbiter, multiplier ahead of the ALU.
 * Grants only while no ack is out, registers the winner onto the bus.
 */

`timescale 1ns/1ps

module cdb_arbiter (
    input  logic               clock,
    input  logic               reset,
    cdb_if.arb                 alu,
    cdb_if.arb                 mul,
    output logic               cdb_valid_o,
    output ooo_pkg::phys_reg_t cdb_dest_o,
    output ooo_pkg::data_t     cdb_value_o,
    output ooo_pkg::rob_idx_t  cdb_rob_idx_o
);

    logic idle;
    logic grant_mul;
    logic grant_alu;

    assign idle      = !alu.ack && !mul.ack;
    assign grant_mul = idle && mul.req;
    assign grant_alu = idle && alu.req && !mul.req;

    always_ff @(posedge clock) begin
        if (reset) begin
            alu.ack     <= 1'b0;
            mul.ack     <= 1'b0;
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= grant_mul || grant_alu;
            // Ack stays up until the unit drops req
            if (grant_mul) begin
                mul.ack <= 1'b1;
            end else if (mul.ack && !mul.req) begin
                mul.ack <= 1'b0;
            end
            if (grant_alu) begin
                alu.ack <= 1'b1;
            end else if (alu.ack && !alu.req) begin
                alu.ack <= 1'b0;
            end
        end
    end

    // Broadcast payload
    always_ff @(posedge clock) begin
        if (grant_mul) begin
            cdb_dest_o    <= mul.dest;
            cdb_value_o   <= mul.value;
            cdb_rob_idx_o <= mul.rob_idx;
        end else if (grant_alu) begin
            cdb_dest_o    <= alu.dest;
            cdb_value_o   <= alu.value;
            cdb_rob_idx_o <= alu.rob_idx;
        end
    end

endmodule

// ==== design/reorder_buffer.sv ====
/*
 * Reorder buffer, 8 entries, head/tail pointers and a count.
 * Entries complete from the CDB, retire in program order.
 */

`timescale 1ns/1ps

module reorder_buffer (
    input  logic               clock,
    input  logic               reset,
    input  logic               alloc_i,
    input  ooo_pkg::arch_reg_t alloc_rd_i,
    input  ooo_pkg::phys_reg_t alloc_old_tag_i,
    output logic               full_o,
    output ooo_pkg::rob_idx_t  tail_o,
    input  logic               cdb_valid_i,
    input  ooo_pkg::rob_idx_t  cdb_rob_idx_i,
    input  ooo_pkg::data_t     cdb_value_i,
    output logic               commit_valid_o,
    output ooo_pkg::arch_reg_t commit_rd_o,
    output ooo_pkg::data_t     commit_value_o,
    output logic               free_valid_o,
    output ooo_pkg::phys_reg_t free_tag_o
);

    logic [ooo_pkg::ROB_DEPTH-1:0] done;
    ooo_pkg::arch_reg_t            rd      [ooo_pkg::ROB_DEPTH];
    ooo_pkg::phys_reg_t            old_tag [ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t                value   [ooo_pkg::ROB_DEPTH];
    ooo_pkg::rob_idx_t             head;
    ooo_pkg::rob_idx_t             tail;
    ooo_pkg::rob_cnt_t             count;
    logic                          commit;

    assign full_o = (count == ooo_pkg::rob_cnt_t'(ooo_pkg::ROB_DEPTH));
    assign tail_o = tail;

    ////////////////////////////////////////
    // Commit at the head
    ////////////////////////////////////////

    assign commit         = (count != '0) && done[head];
    assign commit_valid_o = commit;
    assign commit_rd_o    = rd[head];
    assign commit_value_o = value[head];
    // Old mapping is dead once this entry retires
    assign free_valid_o   = commit;
    assign free_tag_o     = old_tag[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_i) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid_i) begin
                done[cdb_rob_idx_i] <= 1'b1;
            end
            if (commit) begin
                head <= head + 1'b1;
            end
            if (alloc_i && !commit) begin
                count <= count + 1'b1;
            end else if (commit && !alloc_i) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (alloc_i) begin
            rd[tail]      <= alloc_rd_i;
            old_tag[tail] <= alloc_old_tag_i;
        end
        if (cdb_valid_i) begin
            value[cdb_rob_idx_i] <= cdb_value_i;
        end
    end

endmodule

// ==== design/ooo_core.sv ====
/*
 * Out-of-order back end top level.
 * Rename, register file, ALU and multiplier, CDB arbiter, reorder buffer.
 */

`timescale 1ns/1ps

module ooo_core (
    input  logic               clock,
    input  logic               reset,
    input  logic               disp_req_i,
    input  ooo_pkg::opcode_e   disp_op_i,
    input  ooo_pkg::arch_reg_t disp_rd_i,
    input  ooo_pkg::arch_reg_t disp_rs1_i,
    input  ooo_pkg::arch_reg_t disp_rs2_i,
    input  ooo_pkg::data_t     disp_imm_i,
    output logic               disp_ack_o,
    output logic               commit_valid_o,
    output ooo_pkg::arch_reg_t commit_rd_o,
    output ooo_pkg::data_t     commit_value_o
);

    // Rename to register file
    ooo_pkg::phys_reg_t rs1_tag;
    ooo_pkg::phys_reg_t rs2_tag;
    ooo_pkg::data_t     rs1_value;
    ooo_pkg::data_t     rs2_value;
    logic               rs1_ready;
    logic               rs2_ready;
    logic               alloc_valid;
    ooo_pkg::phys_reg_t alloc_tag;

    // Rename to ROB and back
    logic               rob_full;
    ooo_pkg::rob_idx_t  rob_tail;
    logic               rob_alloc;
    ooo_pkg::arch_reg_t rob_rd;
    ooo_pkg::phys_reg_t rob_old_tag;
    logic               free_valid;
    ooo_pkg::phys_reg_t free_tag;

    // Issue path
    logic               alu_ready;
    logic               mul_ready;
    logic               issue_alu;
    logic               issue_mul;
    ooo_pkg::opcode_e   issue_op;
    ooo_pkg::data_t     issue_imm;
    ooo_pkg::phys_reg_t issue_dest;
    ooo_pkg::rob_idx_t  issue_rob_idx;

    // Common data bus
    logic               cdb_valid;
    ooo_pkg::phys_reg_t cdb_dest;
    ooo_pkg::data_t     cdb_value;
    ooo_pkg::rob_idx_t  cdb_rob_idx;

    cdb_if alu_cdb ();
    cdb_if mul_cdb ();

    dispatch_unit u_dispatch (
        .clock(clock), .reset(reset),
        .disp_req_i(disp_req_i), .disp_op_i(disp_op_i), .disp_rd_i(disp_rd_i),
        .disp_rs1_i(disp_rs1_i), .disp_rs2_i(disp_rs2_i), .disp_imm_i(disp_imm_i),
        .disp_ack_o(disp_ack_o),
        .rs1_tag_o(rs1_tag), .rs2_tag_o(rs2_tag),
        .rs1_ready_i(rs1_ready), .rs2_ready_i(rs2_ready),
        .alloc_valid_o(alloc_valid), .alloc_tag_o(alloc_tag),
        .rob_full_i(rob_full), .rob_tail_i(rob_tail), .rob_alloc_o(rob_alloc),
        .rob_rd_o(rob_rd), .rob_old_tag_o(rob_old_tag),
        .free_valid_i(free_valid), .free_tag_i(free_tag),
        .alu_ready_i(alu_ready), .mul_ready_i(mul_ready),
        .issue_alu_o(issue_alu), .issue_mul_o(issue_mul), .issue_op_o(issue_op),
        .issue_imm_o(issue_imm), .issue_dest_o(issue_dest),
        .issue_rob_idx_o(issue_rob_idx)
    );

    phys_reg_file u_prf (
        .clock(clock), .reset(reset),
        .rs1_tag_i(rs1_tag), .rs2_tag_i(rs2_tag),
        .rs1_value_o(rs1_value), .rs2_value_o(rs2_value),
        .rs1_ready_o(rs1_ready), .rs2_ready_o(rs2_ready),
        .alloc_valid_i(alloc_valid), .alloc_tag_i(alloc_tag),
        .cdb_valid_i(cdb_valid), .cdb_dest_i(cdb_dest), .cdb_value_i(cdb_value)
    );

    alu_unit u_alu (
        .clock(clock), .reset(reset),
        .issue_i(issue_alu), .op_i(issue_op), .src1_i(rs1_value), .src2_i(rs2_value),
        .imm_i(issue_imm), .dest_i(issue_dest), .rob_idx_i(issue_rob_idx),
        .ready_o(alu_ready), .cdb(alu_cdb)
    );

    mul_unit u_mul (
        .clock(clock), .reset(reset),
        .issue_i(issue_mul), .op_i(issue_op), .src1_i(rs1_value), .src2_i(rs2_value),
        .dest_i(issue_dest), .rob_idx_i(issue_rob_idx),
        .ready_o(mul_ready), .cdb(mul_cdb)
    );

    cdb_arbiter u_arbiter (
        .clock(clock), .reset(reset),
        .alu(alu_cdb), .mul(mul_cdb),
        .cdb_valid_o(cdb_valid), .cdb_dest_o(cdb_dest),
        .cdb_value_o(cdb_value), .cdb_rob_idx_o(cdb_rob_idx)
    );

    reorder_buffer u_rob (
        .clock(clock), .reset(reset),
        .alloc_i(rob_alloc), .alloc_rd_i(rob_rd), .alloc_old_tag_i(rob_old_tag),
        .full_o(rob_full), .tail_o(rob_tail),
        .cdb_valid_i(cdb_valid), .cdb_rob_idx_i(cdb_rob_idx), .cdb_value_i(cdb_value),
        .commit_valid_o(commit_valid_o), .commit_rd_o(commit_rd_o),
        .commit_value_o(commit_value_o),
        .free_valid_o(free_valid), .free_tag_o(free_tag)
    );

endmodule

// ==== test/ooo_core_checker.sv ====
/*
 * Protocol checks bound into ooo_core.
 * Dispatch handshake, reset state and CDB ack exclusion.
 */

`timescale 1ns/1ps

module ooo_core_checker (
    input logic clock,
    input logic reset,
    input logic disp_req_i,
    input logic disp_ack_i,
    input logic commit_valid_i,
    input logic alu_ack_i,
    input logic mul_ack_i
);

    // Count of failed assertions
    int failures = 0;

    // Ack only rises in answer to a request
    ack_after_req: assert property (@(posedge clock) disable iff (reset)
        $rose(disp_ack_i) |-> $past(disp_req_i))
    else begin
        failures++;
        $error("dispatch ack rose while no request was pending");
    end

    // Ack drops on the edge after req is seen low
    ack_release: assert property (@(posedge clock) disable iff (reset)
        $fell(disp_req_i) |=> !disp_ack_i)
    else begin
        failures++;
        $error("dispatch ack stayed high after the request was dropped");
    end

    // Quiet outputs once reset lets go
    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> (!commit_valid_i && !disp_ack_i))
    else begin
        failures++;
        $error("commit or dispatch ack active right after reset");
    end

    // One grant at a time on the CDB
    one_cdb_ack: assert property (@(posedge clock) disable iff (reset)
        !(alu_ack_i && mul_ack_i))
    else begin
        failures++;
        $error("ALU and multiplier acked at the same time");
    end

endmodule

bind ooo_core ooo_core_checker u_checker (
    .clock(clock), .reset(reset),
    .disp_req_i(disp_req_i), .disp_ack_i(disp_ack_o),
    .commit_valid_i(commit_valid_o),
    .alu_ack_i(alu_cdb.ack), .mul_ack_i(mul_cdb.ack)
);

// ==== test/ooo_core_tb.sv ====
/*
 * Testbench for the out-of-order back end.
 * LFSR programs, in-order reference model, commit comparison.
 */

`timescale 1ns/1ps

module ooo_core_tb;

    localparam int ACK_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic             clock;
    logic             reset;
    logic             disp_req;
    ooo_pkg::opcode_e disp_op;
    logic [2:0]       disp_rd;
    logic [2:0]       disp_rs1;
    logic [2:0]       disp_rs2;
    ooo_pkg::data_t   disp_imm;
    logic             disp_ack;
    logic             commit_valid;
    logic [2:0]       commit_rd;
    ooo_pkg::data_t   commit_value;

    // Reference model state
    ooo_pkg::data_t   arch_regs [8];
    logic [2:0]       exp_rd [$];
    ooo_pkg::data_t   exp_value [$];
    string            test_name;
    logic [31:0]      lfsr;
    logic             verdict_done;

    ooo_core u_dut (
        .clock(clock), .reset(reset),
        .disp_req_i(disp_req), .disp_op_i(disp_op), .disp_rd_i(disp_rd),
        .disp_rs1_i(disp_rs1), .disp_rs2_i(disp_rs2), .disp_imm_i(disp_imm),
        .disp_ack_o(disp_ack), .commit_valid_o(commit_valid),
        .commit_rd_o(commit_rd), .commit_value_o(commit_value)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_with_failure();
        verdict_done = 1'b1;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // Model update, then four-phase dispatch
    task automatic send_instr(input ooo_pkg::opcode_e op, input logic [2:0] rd,
                              input logic [2:0] rs1, input logic [2:0] rs2,
                              input ooo_pkg::data_t imm);
        ooo_pkg::data_t result;
        int             waited;
        case (op)
            ooo_pkg::OP_LI:  result = imm;
            ooo_pkg::OP_ADD: result = arch_regs[rs1] + arch_regs[rs2];
            ooo_pkg::OP_SUB: result = arch_regs[rs1] - arch_regs[rs2];
            default:         result = arch_regs[rs1] * arch_regs[rs2];
        endcase
        arch_regs[rd] = result;
        exp_rd.push_back(rd);
        exp_value.push_back(result);
        disp_op  = op;
        disp_rd  = rd;
        disp_rs1 = rs1;
        disp_rs2 = rs2;
        disp_imm = imm;
        disp_req = 1'b1;
        waited   = 0;
        while (!disp_ack) begin
            @(posedge clock);
            #1;
            waited++;
            assert (waited < ACK_TIMEOUT) else begin
                $display("%s: dispatch was never acknowledged", test_name);
                stop_with_failure();
            end
        end
        disp_req = 1'b0;
        waited   = 0;
        // Next request only after ack is gone
        while (disp_ack) begin
            @(posedge clock);
            #1;
            waited++;
            assert (waited < ACK_TIMEOUT) else begin
                $display("%s: dispatch ack never dropped", test_name);
                stop_with_failure();
            end
        end
    endtask

    task automatic send_random();
        ooo_pkg::opcode_e op;
        logic [2:0]       rd;
        logic [2:0]       rs1;
        logic [2:0]       rs2;
        ooo_pkg::data_t   imm;
        op  = ooo_pkg::opcode_e'(2'(random_bits(2)));
        rd  = 3'(random_bits(3));
        rs1 = 3'(random_bits(3));
        rs2 = 3'(random_bits(3));
        imm = 16'(random_bits(16));
        send_instr(op, rd, rs1, rs2, imm);
    endtask

    task automatic wait_for_commits();
        int waited;
        waited = 0;
        while (exp_rd.size() != 0) begin
            @(posedge clock);
            #1;
            waited++;
            assert (waited < DRAIN_TIMEOUT) else begin
                $display("%s: %0d commits still missing", test_name, exp_rd.size());
                stop_with_failure();
            end
        end
    endtask

    ////////////////////////////////////////
    // Commit comparison
    ////////////////////////////////////////

    // Sampled mid-cycle, away from the edge
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            assert (exp_rd.size() != 0) else begin
                $display("%s: commit with no instruction outstanding", test_name);
                stop_with_failure();
            end
            assert (commit_rd == exp_rd[0]) else begin
                $display("ERR %s: commit rd expected %0d actual %0d",
                         test_name, exp_rd[0], commit_rd);
                stop_with_failure();
            end
            assert (commit_value == exp_value[0]) else begin
                $display("ERR %s: commit value r%0d expected 0x%04h actual 0x%04h",
                         test_name, exp_rd[0], exp_value[0], commit_value);
                stop_with_failure();
            end
            void'(exp_rd.pop_front());
            void'(exp_value.pop_front());
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        disp_req     = 1'b0;
        disp_op      = ooo_pkg::OP_LI;
        disp_rd      = '0;
        disp_rs1     = '0;
        disp_rs2     = '0;
        disp_imm     = '0;
        lfsr         = 32'h2ce57371;
        verdict_done = 1'b0;
        test_name    = "reset_state";
        for (int i = 0; i < 8; i++) begin
            arch_regs[i] = '0;
        end
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        @(posedge clock);
        #1;
        assert (!disp_ack && !commit_valid) else begin
            $display("%s: outputs active after reset", test_name);
            stop_with_failure();
        end
        // Never-written sources read as zero
        send_instr(ooo_pkg::OP_ADD, 3'd3, 3'd1, 3'd2, '0);
        wait_for_commits();

        test_name = "immediates";
        for (int i = 0; i < 8; i++) begin
            send_instr(ooo_pkg::OP_LI, 3'(i), 3'd0, 3'd0, 16'(random_bits(16)));
        end
        wait_for_commits();

        test_name = "dependent_chain";
        send_instr(ooo_pkg::OP_ADD, 3'd1, 3'd0, 3'd1, '0);
        send_instr(ooo_pkg::OP_SUB, 3'd2, 3'd1, 3'd0, '0);
        send_instr(ooo_pkg::OP_MUL, 3'd3, 3'd2, 3'd1, '0);
        send_instr(ooo_pkg::OP_ADD, 3'd3, 3'd3, 3'd3, '0);
        send_instr(ooo_pkg::OP_MUL, 3'd4, 3'd3, 3'd2, '0);
        send_instr(ooo_pkg::OP_SUB, 3'd0, 3'd4, 3'd3, '0);
        send_instr(ooo_pkg::OP_MUL, 3'd5, 3'd0, 3'd0, '0);
        send_instr(ooo_pkg::OP_ADD, 3'd6, 3'd5, 3'd4, '0);
        wait_for_commits();

        // Three multiplies queue on the bus, the load-immediate gets out first
        test_name = "out_of_order";
        send_instr(ooo_pkg::OP_MUL, 3'd7, 3'd5, 3'd6, '0);
        send_instr(ooo_pkg::OP_MUL, 3'd6, 3'd4, 3'd5, '0);
        send_instr(ooo_pkg::OP_MUL, 3'd5, 3'd3, 3'd4, '0);
        send_instr(ooo_pkg::OP_LI, 3'd0, 3'd0, 3'd0, 16'h1234);
        send_instr(ooo_pkg::OP_ADD, 3'd1, 3'd2, 3'd3, '0);
        send_instr(ooo_pkg::OP_SUB, 3'd2, 3'd4, 3'd3, '0);
        wait_for_commits();

        // More multiplies than ROB entries and spare registers
        test_name = "resource_exhaustion";
        for (int i = 0; i < 24; i++) begin
            send_instr(ooo_pkg::OP_MUL, 3'(i), 3'(i + 1), 3'(i + 2), '0);
        end
        wait_for_commits();

        test_name = "random_program";
        for (int i = 0; i < 200; i++) begin
            send_random();
        end
        wait_for_commits();

        if (u_dut.u_checker.failures == 0) begin
            verdict_done = 1'b1;
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("%0d bound assertions failed", u_dut.u_checker.failures);
            stop_with_failure();
        end
    end

    // Run stopped early without a verdict
    final begin
        if (!verdict_done) begin
            $display("Simulation finished: FAIL");
        end
    end

endmodule

// ==== ooo_core.f ====
design/ooo_pkg.sv
design/cdb_if.sv
design/dispatch_unit.sv
design/phys_reg_file.sv
design/alu_unit.sv
design/mul_unit.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/ooo_core.sv
test/ooo_core_checker.sv
test/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module ooo_core_tb -f ooo_core.f -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ooo_core_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "Pass message not found in simulator output"
exit 1
